// File: files.f
+incdir+include
design/board_pkg.sv
design/reset_seq.sv
design/dip_decode.sv
design/joy_map.sv
design/hotkey_ctl.sv
design/video_out.sv
design/board_top.sv
test/board_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the board glue testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module board_tb -f files.f -o board_sim

./obj_dir/board_sim

// File: test/board_tb.sv
// directed testbench for board_top that runs reset, input mapping, hot key, DIP and video tasks
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module board_tb import board_pkg::*; ();

    logic                     clk_sys;
    logic                     rst;
    logic                     rst_req;
    logic                     downloading;
    logic [`BRD_COREMODW-1:0] core_mod;
    logic [`BRD_STATUSW-1:0]  status;
    logic [`BRD_JOYW-1:0]     board_joy [4];
    key_t                     keys;
    logic [`BRD_COLORW-1:0]   game_r, game_g, game_b;
    logic                     lhbl, lvbl, hs, vs, pxl_cen;
    logic                     game_rst, game_rst_n;
    game_in_t                 game_in;
    dip_t                     dip;
    logic [`BRD_GFXW-1:0]     gfx_en;
    rgb8_t                    video;
    logic                     video_cen;
    logic [31:0]              lcg_state;
    logic                     pause_model;     // expected game pause state
    logic                     joy_pause_seen;  // last driven player 1/2 pause level

    board_top UUT (
        .board_joy1 ( board_joy[0] ),
        .board_joy2 ( board_joy[1] ),
        .board_joy3 ( board_joy[2] ),
        .board_joy4 ( board_joy[3] ),
        .*
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;  // 4 ns period
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // inputs change 1 ns after the edge and outputs are read there too
    task automatic step_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // 0 watches game_rst, 1 watches dip.pause
    function automatic logic flag_value(input int which);
        return (which == 0) ? game_rst : dip.pause;
    endfunction

    task automatic wait_flag(input int which, input logic level, input int limit,
                             input string why);
        int n;
        n = 0;
        while (flag_value(which) !== level && n < limit) begin
            step_cycle();
            n++;
        end
        if (flag_value(which) !== level) begin
            $display("timeout at %0t: %s did not reach %0d %s", $time,
                     (which == 0) ? "game_rst" : "dip.pause", level, why);
            abort_run();
        end
    endtask

    task automatic drive_idle();
        rst_req     = 1'b0;
        downloading = 1'b0;
        core_mod    = '0;
        status      = '0;
        keys        = '0;
        for (int i = 0; i < 4; i++) board_joy[i] = '0;
        joy_pause_seen = 1'b0;
        game_r  = '0;
        game_g  = '0;
        game_b  = '0;
        lhbl    = 1'b0;
        lvbl    = 1'b0;
        hs      = 1'b0;
        vs      = 1'b0;
        pxl_cen = 1'b0;
    endtask

    // random boards and key joysticks while hot keys stay released
    task automatic scramble_inputs();
        logic [31:0] r;
        logic        jp;
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            board_joy[i] = r[15:0];
        end
        jp = board_joy[0][`BRD_PAUSE_BIT] | board_joy[1][`BRD_PAUSE_BIT];
        if (jp && !joy_pause_seen) begin
            pause_model = ~pause_model;  // a player pause press toggles the game pause
        end
        joy_pause_seen = jp;
        r = next_rand();
        keys.joy1    = r[9:0];
        keys.joy2    = r[19:10];
        keys.coin    = r[23:20];
        keys.start   = r[27:24];
        keys.service = r[28];
    endtask

    // rotated screen swaps up/down and left/right
    function automatic logic [`BRD_GAMEJOYW-1:0] swap_dirs(input logic [`BRD_GAMEJOYW-1:0] j);
        logic [`BRD_GAMEJOYW-1:0] s;
        s = j;
        s[0] = j[1];
        s[1] = j[0];
        s[2] = j[3];
        s[3] = j[2];
        return s;
    endfunction

    task automatic test_reset_seq();
        rst = 1'b1;
        repeat (4) step_cycle();
        rst = 1'b0;
        for (int n = 0; n < 250; n++) begin
            step_cycle();
            check_val("game_rst", game_rst, 1);
            check_val("game_rst_n", game_rst_n, 0);
        end
        wait_flag(0, 1'b0, 10, "after rst");
        check_val("game_rst_n", game_rst_n, 0);
        step_cycle();
        check_val("game_rst_n", game_rst_n, 0);
        step_cycle();
        check_val("game_rst_n", game_rst_n, 1);  // two cycles behind game_rst
        for (int k = 0; k < 3; k++) begin
            wait_flag(0, 1'b0, 300, "before a retrigger");
            case (k)
                0: rst_req = 1'b1;
                1: downloading = 1'b1;
                default: status[`ST_FLIP] = ~status[`ST_FLIP];
            endcase
            step_cycle();
            rst_req     = 1'b0;
            downloading = 1'b0;
            wait_flag(0, 1'b1, 2, "after a retrigger");
        end
    endtask

    task automatic test_joy_map();
        logic [`BRD_GAMEJOYW-1:0] e1, e2, e3, e4;
        for (int rot_pass = 0; rot_pass < 2; rot_pass++) begin
            core_mod[`CM_VERTICAL] = rot_pass[0];
            status[`ST_ROTATE]     = 1'b0;
            for (int i = 0; i < 8; i++) begin
                scramble_inputs();
                repeat (3) step_cycle();
                e1 = board_joy[0][`BRD_GAMEJOYW-1:0] | keys.joy1;
                e2 = board_joy[1][`BRD_GAMEJOYW-1:0] | keys.joy2;
                if (rot_pass == 1) begin
                    e1 = swap_dirs(e1);
                    e2 = swap_dirs(e2);
                end
                e1 = ~e1;
                e2 = ~e2;
                e3 = ~board_joy[2][`BRD_GAMEJOYW-1:0];
                e4 = ~board_joy[3][`BRD_GAMEJOYW-1:0];
                check_val("game_in.joy1", game_in.joy1, e1);
                check_val("game_in.joy2", game_in.joy2, e2);
                check_val("game_in.joy3", game_in.joy3, e3);
                check_val("game_in.joy4", game_in.joy4, e4);
            end
        end
    endtask

    task automatic test_coin_start();
        logic [3:0] ec, es;
        logic       esv;
        for (int i = 0; i < 8; i++) begin
            scramble_inputs();
            repeat (3) step_cycle();
            for (int p = 0; p < 4; p++) begin
                ec[p] = ~(board_joy[p][`BRD_COIN_BIT] | keys.coin[p]);
                es[p] = ~(board_joy[p][`BRD_START_BIT] | keys.start[p]);
            end
            esv = ~keys.service;
            check_val("game_in.coin", game_in.coin, ec);
            check_val("game_in.start", game_in.start, es);
            check_val("game_in.service", game_in.service, esv);
        end
    endtask

    task automatic test_hotkeys();
        logic                 p0;
        logic [`BRD_GFXW-1:0] ge;
        drive_idle();
        repeat (3) step_cycle();
        p0 = pause_model;
        check_val("dip.pause", dip.pause, p0);
        keys.pause = 1'b1;
        step_cycle();
        keys.pause = 1'b0;
        wait_flag(1, ~p0, 3, "after the pause key");
        board_joy[1][`BRD_PAUSE_BIT] = 1'b1;  // player 2 pause button
        step_cycle();
        board_joy[1][`BRD_PAUSE_BIT] = 1'b0;
        wait_flag(1, p0, 4, "after the player 2 pause button");
        ge = '1;  // every layer enabled since reset
        for (int n = 0; n < `BRD_GFXW; n++) begin
            keys.gfx[n] = 1'b1;
            step_cycle();
            keys.gfx[n] = 1'b0;
            step_cycle();
            ge[n] = ~ge[n];
            check_val("gfx_en", gfx_en, ge);
        end
        wait_flag(0, 1'b0, 300, "before the reset key");
        keys.reset = 1'b1;
        step_cycle();
        keys.reset = 1'b0;
        wait_flag(0, 1'b1, 3, "after the reset key");
    endtask

    task automatic test_dip_decode();
        logic [31:0] r;
        logic        vert, efm, epsg;
        logic [1:0]  erot;
        logic [7:0]  ex, ey;
        for (int i = 0; i < 12; i++) begin
            status = next_rand();
            r = next_rand();
            core_mod = r[6:0];
            core_mod[`CM_VERTICAL] = (i % 3 == 0);  // cycle through the aspect cases
            status[`ST_ASPECT]     = (i % 3 == 1);
            repeat (2) step_cycle();
            vert = core_mod[`CM_VERTICAL];
            efm  = ~status[`ST_NOFM];
            epsg = ~status[`ST_NOPSG];
            erot = {1'b0, vert & ~status[`ST_ROTATE]};
            if (vert) begin
                ex = 8'd3;
                ey = 8'd4;
            end else if (status[`ST_ASPECT]) begin
                ex = 8'd16;
                ey = 8'd9;
            end else begin
                ex = 8'd4;
                ey = 8'd3;
            end
            check_val("dip.flip", dip.flip, status[`ST_FLIP]);
            check_val("dip.test", dip.test, status[`ST_TEST]);
            check_val("dip.fxlevel", dip.fxlevel, status[`ST_FX_LO +: 2]);
            check_val("dip.enable_fm", dip.enable_fm, efm);
            check_val("dip.enable_psg", dip.enable_psg, epsg);
            check_val("dip.rotate", dip.rotate, erot);
            check_val("dip.arx", dip.arx, ex);
            check_val("dip.ary", dip.ary, ey);
        end
    endtask

    task automatic test_video();
        logic [31:0]            r;
        logic [`BRD_COLORW-1:0] cr, cg, cb;
        logic                   ehs, evs, ede;
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            game_r  = r[3:0];
            game_g  = r[7:4];
            game_b  = r[11:8];
            lhbl    = r[12];
            lvbl    = r[13];
            hs      = r[14];
            vs      = r[15];
            pxl_cen = ~i[0];  // every other cycle
            if (pxl_cen) begin
                cr  = game_r;
                cg  = game_g;
                cb  = game_b;
                ehs = hs;
                evs = vs;
                ede = lhbl & lvbl;
            end
            step_cycle();
            check_val("video_cen", video_cen, pxl_cen);
            if (video_cen) begin
                check_val("video.r", video.r, {cr, cr});
                check_val("video.g", video.g, {cg, cg});
                check_val("video.b", video.b, {cb, cb});
                check_val("video.hs", video.hs, ehs);
                check_val("video.vs", video.vs, evs);
                check_val("video.de", video.de, ede);
            end
        end
        pxl_cen = 1'b0;
    endtask

    initial begin
        lcg_state   = 32'h4159d5f8;
        pause_model = 1'b0;
        rst = 1'b1;
        drive_idle();
        test_reset_seq();
        test_joy_map();
        test_coin_start();
        test_hotkeys();
        test_dip_decode();
        test_video();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/board_top.sv
// board glue top level: reset sequencing, input mapping, hot keys, DIP decode and bypass video
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module board_top import board_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic                     rst_req,
    input  logic                     downloading,
    input  logic [`BRD_COREMODW-1:0] core_mod,
    input  logic [`BRD_STATUSW-1:0]  status,
    input  logic [`BRD_JOYW-1:0]     board_joy1,
    input  logic [`BRD_JOYW-1:0]     board_joy2,
    input  logic [`BRD_JOYW-1:0]     board_joy3,
    input  logic [`BRD_JOYW-1:0]     board_joy4,
    input  key_t                     keys,
    input  logic [`BRD_COLORW-1:0]   game_r,
    input  logic [`BRD_COLORW-1:0]   game_g,
    input  logic [`BRD_COLORW-1:0]   game_b,
    input  logic                     lhbl,
    input  logic                     lvbl,
    input  logic                     hs,
    input  logic                     vs,
    input  logic                     pxl_cen,
    output logic                     game_rst,
    output logic                     game_rst_n,
    output game_in_t                 game_in,
    output dip_t                     dip,
    output logic [`BRD_GFXW-1:0]     gfx_en,
    output rgb8_t                    video,
    output logic                     video_cen
);
    logic soft_rst;
    logic game_pause;
    logic joy_pause;
    logic rot_control;

    reset_seq u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .soft_rst    ( soft_rst    ),
        .flip        ( dip.flip    ), // a flip change restarts the game
        .game_rst    ( game_rst    ),
        .game_rst_n  ( game_rst_n  )
    );

    dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .status      ( status      ),
        .core_mod    ( core_mod    ),
        .game_pause  ( game_pause  ),
        .dip         ( dip         ),
        .rot_control ( rot_control )
    );

    joy_map #(.active_low(1'b1)) u_joy (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .board_joy1  ( board_joy1  ),
        .board_joy2  ( board_joy2  ),
        .board_joy3  ( board_joy3  ),
        .board_joy4  ( board_joy4  ),
        .keys        ( keys        ),
        .rot_control ( rot_control ),
        .game_in     ( game_in     ),
        .joy_pause   ( joy_pause   )
    );

    hotkey_ctl u_hotkey (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .keys        ( keys        ),
        .joy_pause   ( joy_pause   ),
        .game_pause  ( game_pause  ),
        .soft_rst    ( soft_rst    ),
        .gfx_en      ( gfx_en      )
    );

    video_out u_video (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .game_r      ( game_r      ),
        .game_g      ( game_g      ),
        .game_b      ( game_b      ),
        .lhbl        ( lhbl        ),
        .lvbl        ( lvbl        ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .pxl_cen     ( pxl_cen     ),
        .video       ( video       ),
        .video_cen   ( video_cen   )
    );

endmodule

`default_nettype wire

// File: design/video_out.sv
// bypass video output, captures the game pixel on pxl_cen and widens colour to 8 bits
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module video_out import board_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [`BRD_COLORW-1:0] game_r,
    input  logic [`BRD_COLORW-1:0] game_g,
    input  logic [`BRD_COLORW-1:0] game_b,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic                   hs,
    input  logic                   vs,
    input  logic                   pxl_cen,
    output rgb8_t                  video,
    output logic                   video_cen
);
    // repeat the colour bits from the msb down until 8 bits are filled
    function automatic logic [7:0] widen(input logic [`BRD_COLORW-1:0] c);
        logic [7:0] w;
        for (int i = 0; i < 8; i++) begin
            w[7-i] = c[`BRD_COLORW-1 - (i % `BRD_COLORW)];
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video     <= '0;
            video_cen <= 1'b0;
        end else begin
            video_cen <= pxl_cen;
            if (pxl_cen) begin
                video.r  <= widen(game_r);
                video.g  <= widen(game_g);
                video.b  <= widen(game_b);
                video.hs <= hs;
                video.vs <= vs;
                video.de <= lhbl & lvbl;  // active outside both blanks
            end
        end
    end

endmodule

`default_nettype wire

// File: design/hotkey_ctl.sv
// hot key edge detection for pause, graphics layer toggles and the soft reset pulse
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module hotkey_ctl import board_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  key_t                 keys,
    input  logic                 joy_pause,
    output logic                 game_pause,
    output logic                 soft_rst,
    output logic [`BRD_GFXW-1:0] gfx_en
);
    logic                 last_pause;
    logic                 last_reset;
    logic                 last_joypause;
    logic [`BRD_GFXW-1:0] last_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause    <= 1'b0;
            last_reset    <= 1'b0;
            last_joypause <= 1'b0;
            last_gfx      <= '0;
            game_pause    <= 1'b0;
            soft_rst      <= 1'b0;
            gfx_en        <= '1;  // all layers on
        end else begin
            last_pause    <= keys.pause;
            last_reset    <= keys.reset;
            last_joypause <= joy_pause;
            last_gfx      <= keys.gfx;
            soft_rst      <= keys.reset & ~last_reset;
            // either pause source toggles, simultaneous edges count once
            if ((keys.pause & ~last_pause) | (joy_pause & ~last_joypause))
                game_pause <= ~game_pause;
            gfx_en <= gfx_en ^ (keys.gfx & ~last_gfx);
        end
    end

endmodule

`default_nettype wire

// File: design/joy_map.sv
// synchronises the board joysticks and merges keyboard keys into the game input word
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module joy_map import board_pkg::*; #(
    parameter bit active_low = 1'b1  // game reads inverted inputs
) (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic [`BRD_JOYW-1:0] board_joy1,
    input  logic [`BRD_JOYW-1:0] board_joy2,
    input  logic [`BRD_JOYW-1:0] board_joy3,
    input  logic [`BRD_JOYW-1:0] board_joy4,
    input  key_t                 keys,
    input  logic                 rot_control,
    output game_in_t             game_in,
    output logic                 joy_pause
);
    logic [`BRD_JOYW-1:0] joy_sync [4];
    game_in_t             mapped;

    // swaps up/down and left/right for a rotated screen
    function automatic logic [`BRD_GAMEJOYW-1:0] rotate_joy(
        input logic [`BRD_GAMEJOYW-1:0] joy,
        input logic                     rot
    );
        rotate_joy = rot ? {joy[`BRD_GAMEJOYW-1:4], joy[2], joy[3], joy[0], joy[1]} : joy;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy_sync[0] <= board_joy1;
        joy_sync[1] <= board_joy2;
        joy_sync[2] <= board_joy3;
        joy_sync[3] <= board_joy4;
    end

    assign joy_pause = joy_sync[0][`BRD_PAUSE_BIT] | joy_sync[1][`BRD_PAUSE_BIT];

    always_comb begin
        mapped.joy1 = rotate_joy(joy_sync[0][`BRD_GAMEJOYW-1:0] | keys.joy1, rot_control);
        mapped.joy2 = rotate_joy(joy_sync[1][`BRD_GAMEJOYW-1:0] | keys.joy2, rot_control);
        mapped.joy3 = joy_sync[2][`BRD_GAMEJOYW-1:0];  // no rotation for players 3 and 4
        mapped.joy4 = joy_sync[3][`BRD_GAMEJOYW-1:0];
        for (int i = 0; i < 4; i++) begin
            mapped.coin[i]  = joy_sync[i][`BRD_COIN_BIT] | keys.coin[i];
            mapped.start[i] = joy_sync[i][`BRD_START_BIT] | keys.start[i];
        end
        mapped.service = keys.service;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_in <= {$bits(game_in_t){active_low}};  // all inactive
        end else begin
            game_in <= mapped ^ {$bits(game_in_t){active_low}};
        end
    end

endmodule

`default_nettype wire

// File: design/dip_decode.sv
// decodes the OSD status word and core mode into registered DIP settings and aspect ratio
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module dip_decode import board_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic [`BRD_STATUSW-1:0]  status,
    input  logic [`BRD_COREMODW-1:0] core_mod,
    input  logic                     game_pause,
    output dip_t                     dip,
    output logic                     rot_control
);
    logic vertical;

    assign vertical    = core_mod[`CM_VERTICAL];
    assign rot_control = dip.rotate[0];  // joystick swap follows screen rotation

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dip     <= '0;
            dip.arx <= 8'd4;
            dip.ary <= 8'd3;
        end else begin
            dip.flip       <= status[`ST_FLIP];
            dip.test       <= status[`ST_TEST];
            dip.pause      <= game_pause | status[`ST_PAUSE];
            dip.enable_fm  <= ~status[`ST_NOFM];
            dip.enable_psg <= ~status[`ST_NOPSG];
            dip.fxlevel    <= status[`ST_FX_LO +: 2];
            dip.rotate     <= {1'b0, vertical & ~status[`ST_ROTATE]};
            if (vertical) begin
                dip.arx <= 8'd3;
                dip.ary <= 8'd4;
            end else if (status[`ST_ASPECT]) begin
                dip.arx <= 8'd16;  // wide screen
                dip.ary <= 8'd9;
            end else begin
                dip.arx <= 8'd4;
                dip.ary <= 8'd3;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/reset_seq.sv
// game reset sequencer, holds game_rst for a fixed time after any reset trigger
`timescale 1ns/1ps
`default_nettype none

`include "board_consts.svh"

module reset_seq (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic game_rst,
    output logic game_rst_n
);
    localparam int hold_len = `BRD_GAME_RST_LEN;
    localparam int cnt_w    = $clog2(hold_len + 1);

    logic             last_flip;
    logic [cnt_w-1:0] hold_cnt;
    logic             pre_rst_n;
    logic             trigger;

    // rst is itself a trigger, so it also masks the first flip compare
    assign trigger = rst | downloading | rst_req | soft_rst | (flip != last_flip);

    always_ff @(posedge clk_sys) begin
        last_flip <= flip;
        if (trigger) begin
            hold_cnt <= '0;
            game_rst <= 1'b1;
        end else if (hold_cnt != cnt_w'(hold_len)) begin
            hold_cnt <= hold_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;  // released once the count saturates
        end
    end

    // active-low copy, released two cycles after game_rst
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

`default_nettype wire

// File: design/board_pkg.sv
// shared packed types for the board glue RTL and its testbench, import with board_pkg::*
`default_nettype none

`include "board_consts.svh"

package board_pkg;

    // keyboard state, already decoded upstream
    typedef struct packed {
        logic [`BRD_GAMEJOYW-1:0] joy1;
        logic [`BRD_GAMEJOYW-1:0] joy2;
        logic [3:0]               start;
        logic [3:0]               coin;
        logic                     reset;   // soft reset hot key
        logic                     pause;
        logic                     service;
        logic [`BRD_GFXW-1:0]     gfx;
    } key_t;

    // inputs as the game core sees them
    typedef struct packed {
        logic [`BRD_GAMEJOYW-1:0] joy1;
        logic [`BRD_GAMEJOYW-1:0] joy2;
        logic [`BRD_GAMEJOYW-1:0] joy3;
        logic [`BRD_GAMEJOYW-1:0] joy4;
        logic [3:0]               coin;    // bit n is player n+1
        logic [3:0]               start;
        logic                     service;
    } game_in_t;

    typedef struct packed {
        logic       flip;
        logic       test;
        logic       pause;
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;
        logic [1:0] rotate;
        logic [7:0] arx;     // hdmi aspect ratio
        logic [7:0] ary;
    } dip_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;
    } rgb8_t;

endpackage

`default_nettype wire

// File: include/board_consts.svh
// board-level widths, OSD status bit positions and reset length; include where needed
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

`define BRD_COLORW       4   // game colour bits per channel
`define BRD_JOYW         16  // board joystick word
`define BRD_GAMEJOYW     10
`define BRD_BUTTONS      2
`define BRD_GFXW         4   // graphics layer enables
`define BRD_STATUSW      32
`define BRD_COREMODW     7

// control bits inside the joystick word move up with extra buttons
`define BRD_START_BIT    (6 + `BRD_BUTTONS - 2)
`define BRD_COIN_BIT     (7 + `BRD_BUTTONS - 2)
`define BRD_PAUSE_BIT    (8 + `BRD_BUTTONS - 2)

`define BRD_GAME_RST_LEN 255 // hold cycles after the last trigger

// OSD status word
`define ST_ASPECT        2
`define ST_ROTATE        3
`define ST_FLIP          4
`define ST_TEST          5
`define ST_PAUSE         6
`define ST_NOFM          7
`define ST_NOPSG         8
`define ST_FX_LO         9   // two bits
`define CM_VERTICAL      0   // core mode bit

`endif
